//--- gnn_settings.svh
/*
 * engine sizes for the GNN layer engine
 *   edge PE count, node id range and width
 *   feature, aggregate and weight widths
 */
`ifndef GNN_SETTINGS_SVH
`define GNN_SETTINGS_SVH

// edge PEs, node n is owned by PE n % count
`define GNN_NUM_EDGE_PE 2

// node id space
`define GNN_MAX_NODES 16
`define GNN_NODE_W 4

// unsigned input feature
`define GNN_FV_W 8

// aggregate and result, wraps mod 2^16
`define GNN_ACC_W 16

// layer weight
`define GNN_WEIGHT_W 8

`endif

//--- gnn_pkg.sv
/*
 * shared types of the GNN layer engine
 *   scalar types for ids, features, aggregates
 *   command views and the command union
 *   feature write, edge task, aggregate packet, result
 */
`include "gnn_settings.svh"

package gnn_pkg;

    // scalar types
    typedef logic [`GNN_NODE_W-1:0] node_id_t;
    typedef logic [`GNN_NODE_W:0] node_cnt_t;
    typedef logic [$clog2(`GNN_MAX_NODES / `GNN_NUM_EDGE_PE)-1:0] bank_idx_t;
    typedef logic [`GNN_FV_W-1:0] fv_t;
    typedef logic [`GNN_ACC_W-1:0] acc_t;
    typedef logic [`GNN_WEIGHT_W-1:0] weight_t;

    // zero is left unused so an idle bus is no command
    typedef enum logic [1:0] {
        CMD_HDR  = 2'd1,
        CMD_EDGE = 2'd2,
        CMD_END  = 2'd3
    } cmd_kind_e;

    // edge view, kind sits in the top bits of both views
    typedef struct packed {
        cmd_kind_e kind;
        node_id_t dst;
        node_id_t src;
        logic [16-2-2*`GNN_NODE_W-1:0] pad;
    } edge_cmd_t;

    // header view, node count 1 to 16
    typedef struct packed {
        cmd_kind_e kind;
        weight_t weight;
        node_cnt_t node_cnt;
        logic [16-2-`GNN_WEIGHT_W-`GNN_NODE_W-1-1:0] pad;
    } hdr_cmd_t;

    // one 16-bit command word, two decodings
    typedef union packed {
        edge_cmd_t edge_cmd;
        hdr_cmd_t hdr;
    } cmd_word_u;

    // host feature write
    typedef struct packed {
        node_id_t node;
        fv_t fv;
    } fv_wr_t;

    // dispatch to edge PE
    typedef struct packed {
        logic valid;
        bank_idx_t idx;
        node_id_t src;
    } edge_task_t;

    // drained aggregate from an edge PE
    typedef struct packed {
        logic valid;
        node_id_t node;
        acc_t acc;
    } agg_pkt_t;

    typedef struct packed {
        node_id_t node;
        acc_t acc;
    } vertex_result_t;

endpackage

//--- feature_mem.sv
/*
 * feature_mem
 *   node feature register file, cleared by reset
 *   one host write port
 *   one registered read port per edge PE
 */
`include "gnn_settings.svh"

module feature_mem (
    input  logic clk,
    input  logic rst,
    input  logic fv_wr_valid,
    input  gnn_pkg::fv_wr_t fv_wr,
    input  gnn_pkg::node_id_t [`GNN_NUM_EDGE_PE-1:0] rd_node,
    output gnn_pkg::fv_t [`GNN_NUM_EDGE_PE-1:0] rd_fv
);

    gnn_pkg::fv_t mem [`GNN_MAX_NODES];

    // host write
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int n = 0; n < `GNN_MAX_NODES; n++) begin
                mem[n] <= '0;
            end
        end else if (fv_wr_valid) begin
            mem[fv_wr.node] <= fv_wr.fv;
        end
    end

    // feature arrives one cycle after the address
    always_ff @(posedge clk) begin
        for (int p = 0; p < `GNN_NUM_EDGE_PE; p++) begin
            rd_fv[p] <= mem[rd_node[p]];
        end
    end

endmodule

//--- edge_pe.sv
/*
 * edge_pe
 *   accumulation bank for the nodes owned by one PE
 *   two-stage read-add-write pipeline with forwarding
 *   drain port that reads and clears one entry
 */
`include "gnn_settings.svh"

module edge_pe #(
    parameter int pe_tag = 0
) (
    input  logic clk,
    input  logic rst,
    input  gnn_pkg::edge_task_t task_in,
    input  gnn_pkg::fv_t fv,
    input  logic drain_strobe,
    input  gnn_pkg::bank_idx_t drain_index,
    output gnn_pkg::node_id_t rd_node,
    output gnn_pkg::agg_pkt_t agg_out
);

    localparam int NUM_PE = `GNN_NUM_EDGE_PE;
    localparam int BANK_DEPTH = `GNN_MAX_NODES / `GNN_NUM_EDGE_PE;

    gnn_pkg::acc_t bank [BANK_DEPTH];

    // stage one, bank value and target index
    logic s1_valid;
    gnn_pkg::bank_idx_t s1_idx;
    gnn_pkg::acc_t s1_old;

    gnn_pkg::acc_t bank_rd;
    gnn_pkg::acc_t sum;

    // source feature is fetched while the bank is read
    assign rd_node = task_in.src;

    // stage two sum, feature zero extended, wraps
    assign sum = s1_old + gnn_pkg::acc_t'(fv);

    // forward the sum being written when the index repeats
    always_comb begin
        bank_rd = bank[task_in.idx];
        if (s1_valid && s1_idx == task_in.idx) begin
            bank_rd = sum;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= task_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_idx <= task_in.idx;
        s1_old <= bank_rd;
    end

    // bank write and drain clear
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int b = 0; b < BANK_DEPTH; b++) begin
                bank[b] <= '0;
            end
        end else begin
            if (s1_valid) begin
                bank[s1_idx] <= sum;
            end
            // no edge is in flight during the sweep
            if (drain_strobe) begin
                bank[drain_index] <= '0;
            end
        end
    end

    // drained entry, global id rebuilt from local index and tag
    always_ff @(posedge clk) begin
        if (rst) begin
            agg_out <= '0;
        end else begin
            agg_out.valid <= drain_strobe;
            agg_out.node <= gnn_pkg::node_id_t'(int'(drain_index) * NUM_PE + pe_tag);
            agg_out.acc <= bank[drain_index];
        end
    end

endmodule

//--- vertex_pe.sv
/*
 * vertex_pe
 *   two-stage weight multiply of drained aggregates
 *   stage one operands, stage two truncated product
 */
`include "gnn_settings.svh"

module vertex_pe (
    input  logic clk,
    input  logic rst,
    input  gnn_pkg::agg_pkt_t agg_in,
    input  gnn_pkg::weight_t weight,
    output logic result_valid,
    output gnn_pkg::vertex_result_t result
);

    logic s1_valid;
    gnn_pkg::node_id_t s1_node;
    gnn_pkg::acc_t s1_acc;
    gnn_pkg::weight_t s1_weight;
    logic [`GNN_ACC_W+`GNN_WEIGHT_W-1:0] product;

    // full width product, low bits kept
    assign product = s1_acc * s1_weight;

    // valid bits, one per stage
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            s1_valid <= agg_in.valid;
            result_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_node <= agg_in.node;
        s1_acc <= agg_in.acc;
        s1_weight <= weight;
        result.node <= s1_node;
        result.acc <= product[`GNN_ACC_W-1:0];
    end

endmodule

//--- task_dispatch.sv
/*
 * task_dispatch
 *   command decode through the command union
 *   edge routing to the owner PE of the destination node
 *   settle wait, drain sweep and vertex pipeline flush
 *   busy level and task_complete pulse
 */
`include "gnn_settings.svh"

module task_dispatch (
    input  logic clk,
    input  logic rst,
    input  logic cmd_valid,
    input  gnn_pkg::cmd_word_u cmd,
    input  gnn_pkg::agg_pkt_t [`GNN_NUM_EDGE_PE-1:0] pe_agg,
    output gnn_pkg::edge_task_t [`GNN_NUM_EDGE_PE-1:0] edge_task,
    output logic [`GNN_NUM_EDGE_PE-1:0] drain_strobe,
    output gnn_pkg::bank_idx_t drain_index,
    output gnn_pkg::agg_pkt_t vertex_in,
    output gnn_pkg::weight_t weight,
    output logic busy,
    output logic task_complete
);

    localparam int NUM_PE = `GNN_NUM_EDGE_PE;
    // edge pipeline depth after the last edge
    localparam int SETTLE_CYCLES = 2;
    // one PE read cycle plus two vertex stages
    localparam int FLUSH_CYCLES = 3;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ACCEPT,
        S_SETTLE,
        S_SWEEP,
        S_FLUSH
    } state_e;

    state_e state;
    logic [1:0] wait_cnt;
    gnn_pkg::node_id_t sweep_node;
    gnn_pkg::node_cnt_t node_cnt;
    gnn_pkg::cmd_kind_e kind;
    logic edge_go;

    // kind field is shared by both views
    assign kind = cmd.hdr.kind;
    assign edge_go = (state == S_ACCEPT) && cmd_valid && (kind == gnn_pkg::CMD_EDGE);
    assign busy = (state != S_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            wait_cnt <= '0;
            sweep_node <= '0;
            node_cnt <= '0;
            weight <= '0;
            task_complete <= 1'b0;
        end else begin
            task_complete <= 1'b0;
            case (state)
                S_IDLE: begin
                    // header latches layer weight and node count
                    if (cmd_valid && kind == gnn_pkg::CMD_HDR) begin
                        weight <= cmd.hdr.weight;
                        node_cnt <= cmd.hdr.node_cnt;
                        state <= S_ACCEPT;
                    end
                end
                S_ACCEPT: begin
                    if (cmd_valid && kind == gnn_pkg::CMD_END) begin
                        wait_cnt <= '0;
                        state <= S_SETTLE;
                    end
                end
                S_SETTLE: begin
                    wait_cnt <= wait_cnt + 2'd1;
                    if (wait_cnt == 2'(SETTLE_CYCLES - 1)) begin
                        wait_cnt <= '0;
                        sweep_node <= '0;
                        state <= S_SWEEP;
                    end
                end
                S_SWEEP: begin
                    // one node per cycle, ascending
                    sweep_node <= sweep_node + 1'b1;
                    if ({1'b0, sweep_node} == node_cnt - 1'b1) begin
                        wait_cnt <= '0;
                        state <= S_FLUSH;
                    end
                end
                S_FLUSH: begin
                    wait_cnt <= wait_cnt + 2'd1;
                    // last result leaves vertex PE in this cycle
                    if (wait_cnt == 2'(FLUSH_CYCLES - 1)) begin
                        task_complete <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // edge tasks, registered, only the owner PE gets valid
    always_ff @(posedge clk) begin
        if (rst) begin
            edge_task <= '0;
        end else begin
            for (int p = 0; p < NUM_PE; p++) begin
                edge_task[p].valid <= edge_go && (cmd.edge_cmd.dst % NUM_PE == p);
                edge_task[p].idx <= gnn_pkg::bank_idx_t'(cmd.edge_cmd.dst / NUM_PE);
                edge_task[p].src <= cmd.edge_cmd.src;
            end
        end
    end

    // drain strobe to the owner of the swept node
    always_comb begin
        drain_strobe = '0;
        drain_index = gnn_pkg::bank_idx_t'(sweep_node / NUM_PE);
        for (int p = 0; p < NUM_PE; p++) begin
            if (state == S_SWEEP && sweep_node % NUM_PE == p) begin
                drain_strobe[p] = 1'b1;
            end
        end
    end

    // at most one PE answers per cycle
    always_comb begin
        vertex_in = '0;
        for (int p = 0; p < NUM_PE; p++) begin
            if (pe_agg[p].valid) begin
                vertex_in = pe_agg[p];
            end
        end
    end

endmodule

//--- gnn_top.sv
/*
 * gnn_top
 *   task dispatch, feature memory, edge PE array, vertex PE
 *   host feature write and command ports
 *   result stream, busy and task_complete
 */
`include "gnn_settings.svh"

module gnn_top (
    input  logic clk,
    input  logic rst,
    input  logic fv_wr_valid,
    input  gnn_pkg::fv_wr_t fv_wr,
    input  logic cmd_valid,
    input  gnn_pkg::cmd_word_u cmd,
    output logic busy,
    output logic result_valid,
    output gnn_pkg::vertex_result_t result,
    output logic task_complete
);

    // dispatch to edge PEs
    gnn_pkg::edge_task_t [`GNN_NUM_EDGE_PE-1:0] edge_task;
    logic [`GNN_NUM_EDGE_PE-1:0] drain_strobe;
    gnn_pkg::bank_idx_t drain_index;

    // edge PEs back to dispatch and feature memory
    gnn_pkg::agg_pkt_t [`GNN_NUM_EDGE_PE-1:0] pe_agg;
    gnn_pkg::node_id_t [`GNN_NUM_EDGE_PE-1:0] rd_node;
    gnn_pkg::fv_t [`GNN_NUM_EDGE_PE-1:0] rd_fv;

    // dispatch to vertex PE
    gnn_pkg::agg_pkt_t vertex_in;
    gnn_pkg::weight_t weight;

    task_dispatch task_dispatch_inst (
        .clk(clk),
        .rst(rst),
        .cmd_valid(cmd_valid),
        .cmd(cmd),
        .pe_agg(pe_agg),
        .edge_task(edge_task),
        .drain_strobe(drain_strobe),
        .drain_index(drain_index),
        .vertex_in(vertex_in),
        .weight(weight),
        .busy(busy),
        .task_complete(task_complete)
    );

    feature_mem feature_mem_inst (
        .clk(clk),
        .rst(rst),
        .fv_wr_valid(fv_wr_valid),
        .fv_wr(fv_wr),
        .rd_node(rd_node),
        .rd_fv(rd_fv)
    );

    // one edge PE per owner slot
    for (genvar g = 0; g < `GNN_NUM_EDGE_PE; g++) begin : g_edge_pe
        edge_pe #(
            .pe_tag(g)
        ) edge_pe_inst (
            .clk(clk),
            .rst(rst),
            .task_in(edge_task[g]),
            .fv(rd_fv[g]),
            .drain_strobe(drain_strobe[g]),
            .drain_index(drain_index),
            .rd_node(rd_node[g]),
            .agg_out(pe_agg[g])
        );
    end

    vertex_pe vertex_pe_inst (
        .clk(clk),
        .rst(rst),
        .agg_in(vertex_in),
        .weight(weight),
        .result_valid(result_valid),
        .result(result)
    );

endmodule

//--- gnn_assert.sv
/*
 * gnn_assert
 *   protocol properties of gnn_top, attached by bind
 *   idle after reset, no command in the sweep
 *   results only while busy, one-cycle done pulse
 */
`include "gnn_settings.svh"

module gnn_assert (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic cmd_valid,
    input logic [`GNN_NUM_EDGE_PE-1:0] drain_strobe,
    input logic result_valid,
    input logic task_complete
);

    // failed assertions so far, read by the testbench
    int fail_count = 0;

    // engine idle right after reset
    reset_idle: assert property (@(posedge clk) rst |=> !busy)
        else begin
            fail_count++;
            $error("busy high in the cycle after reset");
        end

    // sweep runs while any drain strobe is high
    no_cmd_in_sweep: assert property (@(posedge clk) disable iff (rst)
        (|drain_strobe) |-> !cmd_valid)
        else begin
            fail_count++;
            $error("command issued during the drain sweep");
        end

    result_in_task: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> busy)
        else begin
            fail_count++;
            $error("result_valid while not busy");
        end

    // done is a pulse
    complete_pulse: assert property (@(posedge clk) disable iff (rst)
        task_complete |=> !task_complete)
        else begin
            fail_count++;
            $error("task_complete longer than one cycle");
        end

endmodule

bind gnn_top gnn_assert gnn_assert_inst (
    .clk(clk),
    .rst(rst),
    .busy(busy),
    .cmd_valid(cmd_valid),
    .drain_strobe(drain_strobe),
    .result_valid(result_valid),
    .task_complete(task_complete)
);

//--- gnn_tb.sv
/*
 * gnn_tb
 *   random graph tasks through gnn_top, fixed seed
 *   model of neighbor sums and weight scaling
 *   compare tasks for status levels, results, completion
 */
`include "gnn_settings.svh"

module gnn_tb;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int N = `GNN_MAX_NODES;

    logic clk;
    logic rst;
    logic fv_wr_valid;
    gnn_pkg::fv_wr_t fv_wr;
    logic cmd_valid;
    gnn_pkg::cmd_word_u cmd;
    logic busy;
    logic result_valid;
    gnn_pkg::vertex_result_t result;
    logic task_complete;

    int seed;
    // model of host features and per-task sums
    int feat [N];
    int agg [N];
    int edge_dst [$];
    int edge_src [$];

    gnn_top gnn_top_inst (
        .clk(clk),
        .rst(rst),
        .fv_wr_valid(fv_wr_valid),
        .fv_wr(fv_wr),
        .cmd_valid(cmd_valid),
        .cmd(cmd),
        .busy(busy),
        .result_valid(result_valid),
        .result(result),
        .task_complete(task_complete)
    );

    always #50 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // bound assertions count their failures
    always @(negedge clk) begin
        if (gnn_top_inst.gnn_assert_inst.fail_count != 0) begin
            fail_run("a protocol assertion failed");
        end
    end

    function automatic int rand_below(input int k);
        rand_below = int'($unsigned($random(seed)) % k);
    endfunction

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_result(input gnn_pkg::vertex_result_t got,
                                input gnn_pkg::vertex_result_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: result got node %h acc %h expected node %h acc %h",
                got.node, got.acc, exp.node, exp.acc));
        end
    endtask

    // done pulse with busy dropping in the same cycle
    task automatic check_complete(input logic done, input logic bsy);
        check_level("task_complete", done, 1'b1);
        check_level("busy", bsy, 1'b0);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy !== 1'b0) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                fail_run("timeout waiting for busy to fall");
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_result(output gnn_pkg::vertex_result_t r);
        int n;
        n = 0;
        @(negedge clk);
        while (result_valid !== 1'b1) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                fail_run("timeout waiting for result_valid");
            end
            @(negedge clk);
        end
        // no early done while results still come
        check_level("task_complete", task_complete, 1'b0);
        r = result;
    endtask

    task automatic write_feature(input int node, input int fv);
        @(negedge clk);
        fv_wr_valid = 1'b1;
        fv_wr.node = gnn_pkg::node_id_t'(node);
        fv_wr.fv = gnn_pkg::fv_t'(fv);
        feat[node] = fv;
    endtask

    // fill all nodes with random values unless a fixed one is given
    task automatic load_features(input int fixed);
        for (int n = 0; n < N; n++) begin
            write_feature(n, (fixed < 0) ? rand_below(256) : fixed);
        end
        @(negedge clk);
        fv_wr_valid = 1'b0;
    endtask

    task automatic send_cmd(input gnn_pkg::cmd_word_u c);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd = c;
    endtask

    task automatic add_edge(input int dst, input int src);
        edge_dst.push_back(dst);
        edge_src.push_back(src);
    endtask

    // send header, queued edges and end and check results in node order
    task automatic run_task(input int cnt, input int wt);
        gnn_pkg::cmd_word_u c;
        gnn_pkg::vertex_result_t got;
        gnn_pkg::vertex_result_t exp;
        wait_idle();
        for (int n = 0; n < N; n++) begin
            agg[n] = 0;
        end
        c = '0;
        c.hdr.kind = gnn_pkg::CMD_HDR;
        c.hdr.weight = gnn_pkg::weight_t'(wt);
        c.hdr.node_cnt = gnn_pkg::node_cnt_t'(cnt);
        send_cmd(c);
        for (int i = 0; i < edge_dst.size(); i++) begin
            c = '0;
            c.edge_cmd.kind = gnn_pkg::CMD_EDGE;
            c.edge_cmd.dst = gnn_pkg::node_id_t'(edge_dst[i]);
            c.edge_cmd.src = gnn_pkg::node_id_t'(edge_src[i]);
            send_cmd(c);
            agg[edge_dst[i]] = (agg[edge_dst[i]] + feat[edge_src[i]]) % 65536;
        end
        c = '0;
        c.hdr.kind = gnn_pkg::CMD_END;
        send_cmd(c);
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd = '0;
        for (int n = 0; n < cnt; n++) begin
            wait_result(got);
            exp.node = gnn_pkg::node_id_t'(n);
            exp.acc = gnn_pkg::acc_t'((agg[n] * wt) % 65536);
            check_result(got, exp);
        end
        // fixed one-cycle gap to the done pulse
        @(negedge clk);
        check_complete(task_complete, busy);
        edge_dst.delete();
        edge_src.delete();
    endtask

    initial begin
        int cnt;
        int num_edges;
        seed = 1403;
        clk = 1'b0;
        rst = 1'b1;
        fv_wr_valid = 1'b0;
        fv_wr = '0;
        cmd_valid = 1'b0;
        cmd = '0;
        for (int n = 0; n < N; n++) begin
            feat[n] = 0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_level("busy", busy, 1'b0);
        check_level("result_valid", result_valid, 1'b0);
        check_level("task_complete", task_complete, 1'b0);

        // single edge gives weight times one feature
        load_features(-1);
        add_edge(5, 2);
        run_task(6, 1 + rand_below(255));

        // random graphs
        for (int t = 0; t < 6; t++) begin
            load_features(-1);
            cnt = 1 + rand_below(N);
            num_edges = rand_below(24);
            for (int i = 0; i < num_edges; i++) begin
                add_edge(rand_below(cnt), rand_below(N));
            end
            run_task(cnt, rand_below(256));
        end

        // back-to-back same destination then alternate indices of one PE
        for (int i = 0; i < 6; i++) begin
            add_edge(3, rand_below(N));
        end
        for (int i = 0; i < 6; i++) begin
            add_edge((i % 2 == 0) ? 4 : 6, rand_below(N));
            add_edge(3, rand_below(N));
        end
        run_task(8, 1 + rand_below(255));

        // odd nodes without edges then a task with none at all
        for (int i = 0; i < 10; i++) begin
            add_edge(2 * rand_below(N / 2), rand_below(N));
        end
        run_task(N, 1 + rand_below(255));
        run_task(N, 1 + rand_below(255));

        // maximum values so the sum passes 2^16
        load_features(255);
        for (int i = 0; i < 300; i++) begin
            add_edge(0, rand_below(N));
        end
        add_edge(1, 7);
        run_task(2, 255);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
gnn_pkg.sv
feature_mem.sv
edge_pe.sv
vertex_pe.sv
task_dispatch.sv
gnn_top.sv
gnn_assert.sv
gnn_tb.sv

//--- Makefile
# Verilator build and run of the GNN layer engine testbench

VERILATOR ?= verilator
TOP ?= gnn_tb
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
BIN ?= $(OBJ_DIR)/V$(TOP)
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
RUN_ARGS ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FILELIST)) gnn_settings.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "no verdict in log"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
